// ==== flist.f ====
+incdir+verification
rtl/ex_op_pkg.sv
rtl/ex_mem_pkg.sv
rtl/regular_alu.sv
rtl/div_alu.sv
rtl/branch_alu.sv
rtl/lsu_agen.sv
rtl/alu.sv
verification/alu_properties.sv
verification/tb_alu.sv

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   ex_valid_i,
    input  ex_op_pkg::word_t       pc_i,
    input  ex_op_pkg::inst_word_u  inst_i,
    input  ex_op_pkg::alu_op_e     aluop_i,
    input  ex_op_pkg::alu_sel_e    alusel_i,
    input  ex_op_pkg::word_t       reg1_i,
    input  ex_op_pkg::word_t       reg2_i,
    input  logic                   pre_taken_i,
    input  ex_op_pkg::word_t       pre_target_i,
    input  logic                   ll_bit_i,
    input  logic                   mem_addr_ok_i,
    output logic                   pause_o,
    output logic                   branch_flush_o,
    output ex_op_pkg::word_t       branch_target_o,
    output logic                   mem_valid_o,
    output logic                   mem_we_o,
    output logic                   mem_uncached_o,
    output ex_op_pkg::word_t       mem_addr_o,
    output ex_op_pkg::word_t       mem_wdata_o,
    output ex_mem_pkg::wstrb_t     mem_wstrb_o,
    output ex_op_pkg::word_t       wb_data_o,
    output logic                   exc_o,
    output ex_mem_pkg::exc_cause_e exc_cause_o
);
    import ex_op_pkg::*;
    import ex_mem_pkg::*;

    word_t      alu_res;
    word_t      quotient;
    word_t      remainder;
    word_t      link;
    word_t      lsu_addr;
    word_t      lsu_wdata;
    wstrb_t     lsu_wstrb;
    exc_cause_e lsu_cause;
    logic       lsu_is_mem;
    logic       lsu_we;
    logic       lsu_exc;
    logic       is_div_op;
    logic       div_signed;
    logic       div_start;
    logic       div_busy;
    logic       div_done;

    regular_alu i_regular_alu (
        .aluop_i (aluop_i),
        .inst_i  (inst_i),
        .pc_i    (pc_i),
        .reg1_i  (reg1_i),
        .reg2_i  (reg2_i),
        .result_o(alu_res)
    );

    assign is_div_op  = aluop_i inside {ALU_DIVW, ALU_MODW, ALU_DIVWU, ALU_MODWU};
    assign div_signed = aluop_i inside {ALU_DIVW, ALU_MODW};
    // done blocks a restart in its own cycle
    assign div_start  = ex_valid_i && is_div_op && !div_busy && !div_done;

    div_alu i_div_alu (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .start_i    (div_start),
        .signed_i   (div_signed),
        .dividend_i (reg1_i),
        .divisor_i  (reg2_i),
        .busy_o     (div_busy),
        .done_o     (div_done),
        .quotient_o (quotient),
        .remainder_o(remainder)
    );

    branch_alu i_branch_alu (
        .aluop_i     (aluop_i),
        .inst_i      (inst_i),
        .pc_i        (pc_i),
        .reg1_i      (reg1_i),
        .reg2_i      (reg2_i),
        .pre_target_i(pre_target_i),
        .pre_taken_i (pre_taken_i),
        .valid_i     (ex_valid_i),
        .flush_o     (branch_flush_o),
        .target_o    (branch_target_o),
        .link_o      (link)
    );

    lsu_agen i_lsu_agen (
        .aluop_i    (aluop_i),
        .inst_i     (inst_i),
        .reg1_i     (reg1_i),
        .reg2_i     (reg2_i),
        .ll_bit_i   (ll_bit_i),
        .is_mem_o   (lsu_is_mem),
        .we_o       (lsu_we),
        .addr_o     (lsu_addr),
        .wdata_o    (lsu_wdata),
        .wstrb_o    (lsu_wstrb),
        .exc_o      (lsu_exc),
        .exc_cause_o(lsu_cause)
    );

    assign exc_o       = ex_valid_i && lsu_exc;
    assign exc_cause_o = exc_o ? lsu_cause : EXC_NONE;

    // cache request, held by upstream while it waits
    assign mem_valid_o    = ex_valid_i && lsu_is_mem && !lsu_exc;
    assign mem_we_o       = mem_valid_o && lsu_we;
    assign mem_uncached_o = mem_valid_o && (lsu_addr[31:16] == UNCACHED_PREFIX);
    assign mem_addr_o     = lsu_addr;
    assign mem_wdata_o    = lsu_wdata;
    assign mem_wstrb_o    = lsu_wstrb;

    assign pause_o = div_start || div_busy || (mem_valid_o && !mem_addr_ok_i);

    always_comb begin
        case (alusel_i)
            SEL_REGULAR: wb_data_o = alu_res;
            SEL_DIV: begin
                if (!div_done) begin
                    wb_data_o = '0;
                end else if (aluop_i inside {ALU_DIVW, ALU_DIVWU}) begin
                    wb_data_o = quotient;
                end else begin
                    wb_data_o = remainder;
                end
            end
            SEL_BRANCH:     wb_data_o = link;
            SEL_LOAD_STORE: wb_data_o = (aluop_i == ALU_SCW) ? {31'b0, ll_bit_i} : '0;
            default:        wb_data_o = '0;
        endcase
    end

endmodule

// ==== rtl/branch_alu.sv ====
`timescale 1ns/1ps

module branch_alu (
    input  ex_op_pkg::alu_op_e    aluop_i,
    input  ex_op_pkg::inst_word_u inst_i,
    input  ex_op_pkg::word_t      pc_i,
    input  ex_op_pkg::word_t      reg1_i,
    input  ex_op_pkg::word_t      reg2_i,
    input  ex_op_pkg::word_t      pre_target_i,
    input  logic                  pre_taken_i,
    input  logic                  valid_i,
    output logic                  flush_o,
    output ex_op_pkg::word_t      target_o,
    output ex_op_pkg::word_t      link_o
);
    import ex_op_pkg::*;

    word_t       offs16_ext;
    word_t       offs26_ext;
    logic [25:0] offs26;
    word_t       seq_pc;
    word_t       jump_target;
    logic        is_branch;
    logic        taken;

    assign offs26     = {inst_i.fmt_i26.offs_hi, inst_i.fmt_i26.offs_lo};
    assign offs16_ext = {{14{inst_i.fmt_ri16.offs16[15]}}, inst_i.fmt_ri16.offs16, 2'b00};
    assign offs26_ext = {{4{offs26[25]}}, offs26, 2'b00};
    assign seq_pc     = pc_i + 32'd4;

    always_comb begin
        is_branch   = 1'b1;
        jump_target = pc_i + offs16_ext;
        case (aluop_i)
            ALU_BEQ:  taken = reg1_i == reg2_i;
            ALU_BNE:  taken = reg1_i != reg2_i;
            ALU_BLT:  taken = $signed(reg1_i) < $signed(reg2_i);
            ALU_BGE:  taken = $signed(reg1_i) >= $signed(reg2_i);
            ALU_BLTU: taken = reg1_i < reg2_i;
            ALU_BGEU: taken = reg1_i >= reg2_i;
            ALU_B, ALU_BL: begin
                taken       = 1'b1;
                jump_target = pc_i + offs26_ext;
            end
            ALU_JIRL: begin
                taken       = 1'b1;
                jump_target = reg1_i + offs16_ext;
            end
            default: begin
                is_branch = 1'b0;
                taken     = 1'b0;
            end
        endcase
    end

    assign target_o = taken ? jump_target : seq_pc;
    assign link_o   = seq_pc;

    // wrong direction, or right direction with a stale target
    assign flush_o = valid_i && is_branch &&
                     ((taken != pre_taken_i) ||
                      (taken && pre_taken_i && (jump_target != pre_target_i)));

endmodule

// ==== rtl/div_alu.sv ====
`timescale 1ns/1ps

module div_alu (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             start_i,
    input  logic             signed_i,
    input  ex_op_pkg::word_t dividend_i,
    input  ex_op_pkg::word_t divisor_i,
    output logic             busy_o,
    output logic             done_o,
    output ex_op_pkg::word_t quotient_o,
    output ex_op_pkg::word_t remainder_o
);
    import ex_op_pkg::*;

    logic                           busy_q;
    logic                           done_q;
    logic [$clog2(DIV_STEPS)-1:0]   step_q;

    word_t rem_q;
    word_t quo_q;
    word_t div_q;
    logic  neg_quo_q;
    logic  neg_rem_q;

    word_t       dividend_mag;
    word_t       divisor_mag;
    logic [32:0] rem_shift;
    logic [33:0] trial;

    // operand magnitudes, only negated for signed ops
    assign dividend_mag = (signed_i && dividend_i[31]) ? -dividend_i : dividend_i;
    assign divisor_mag  = (signed_i && divisor_i[31]) ? -divisor_i : divisor_i;

    // bring down the next dividend bit and try the subtract
    assign rem_shift = {rem_q, quo_q[31]};
    assign trial     = {1'b0, rem_shift} - {2'b0, div_q};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            step_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (busy_q) begin
                step_q <= step_q + 1'b1;
                if (step_q == ($clog2(DIV_STEPS))'(DIV_STEPS - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end else if (start_i) begin
                busy_q <= 1'b1;
                step_q <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy_q) begin
            if (!trial[33]) begin
                rem_q <= trial[31:0];
                quo_q <= {quo_q[30:0], 1'b1};
            end else begin
                rem_q <= rem_shift[31:0];
                quo_q <= {quo_q[30:0], 1'b0};
            end
        end else if (start_i) begin
            rem_q     <= '0;
            quo_q     <= dividend_mag;
            div_q     <= divisor_mag;
            // zero divisor keeps the all-ones quotient unsigned
            neg_quo_q <= signed_i && (dividend_i[31] ^ divisor_i[31]) && (divisor_i != '0);
            neg_rem_q <= signed_i && dividend_i[31];
        end
    end

    assign busy_o = busy_q;
    assign done_o = done_q;

    // truncating result, remainder follows the dividend sign
    assign quotient_o  = neg_quo_q ? -quo_q : quo_q;
    assign remainder_o = neg_rem_q ? -rem_q : rem_q;

endmodule

// ==== rtl/ex_mem_pkg.sv ====
package ex_mem_pkg;

    typedef logic [3:0] wstrb_t;

    localparam wstrb_t WSTRB_FULL = 4'b1111;

    // byte and halfword lane patterns before shifting into place
    localparam wstrb_t WSTRB_BYTE = 4'b0001;
    localparam wstrb_t WSTRB_HALF = 4'b0011;

    typedef enum logic [6:0] {
        EXC_NONE = 7'h00,
        EXC_ALE  = 7'h09
    } exc_cause_e;

    // upper address half of the uncached window
    localparam logic [15:0] UNCACHED_PREFIX = 16'hbfaf;

endpackage

// ==== rtl/ex_op_pkg.sv ====
package ex_op_pkg;

    localparam int DIV_STEPS = 32;

    typedef logic [31:0] word_t;

    typedef enum logic [5:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_NOR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LU12I, ALU_PCADDU12I,
        ALU_DIVW, ALU_MODW, ALU_DIVWU, ALU_MODWU,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_B, ALU_BL, ALU_JIRL,
        ALU_LDB, ALU_LDBU, ALU_LDH, ALU_LDHU, ALU_LDW, ALU_LLW,
        ALU_STB, ALU_STH, ALU_STW, ALU_SCW,
        ALU_NOP
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_REGULAR,
        SEL_DIV,
        SEL_BRANCH,
        SEL_LOAD_STORE,
        SEL_NONE
    } alu_sel_e;

    // one instruction word, read through whichever format the op uses
    typedef union packed {
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] si12;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } fmt_ri12;
        struct packed {
            logic [7:0]  opcode;
            logic [13:0] si14;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } fmt_ri14;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs16;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } fmt_ri16;
        // offs26 upper bits sit in the low field
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs_lo;
            logic [9:0]  offs_hi;
        } fmt_i26;
        struct packed {
            logic [6:0]  opcode;
            logic [19:0] si20;
            logic [4:0]  rd;
        } fmt_ri20;
    } inst_word_u;

endpackage

// ==== rtl/lsu_agen.sv ====
`timescale 1ns/1ps

module lsu_agen (
    input  ex_op_pkg::alu_op_e      aluop_i,
    input  ex_op_pkg::inst_word_u   inst_i,
    input  ex_op_pkg::word_t        reg1_i,
    input  ex_op_pkg::word_t        reg2_i,
    input  logic                    ll_bit_i,
    output logic                    is_mem_o,
    output logic                    we_o,
    output ex_op_pkg::word_t        addr_o,
    output ex_op_pkg::word_t        wdata_o,
    output ex_mem_pkg::wstrb_t      wstrb_o,
    output logic                    exc_o,
    output ex_mem_pkg::exc_cause_e  exc_cause_o
);
    import ex_op_pkg::*;
    import ex_mem_pkg::*;

    word_t si12_ext;
    word_t si14_ext;
    word_t addr_ri12;
    word_t addr_ri14;
    logic  misaligned;

    assign si12_ext  = {{20{inst_i.fmt_ri12.si12[11]}}, inst_i.fmt_ri12.si12};
    assign si14_ext  = {{16{inst_i.fmt_ri14.si14[13]}}, inst_i.fmt_ri14.si14, 2'b00};
    assign addr_ri12 = reg1_i + si12_ext;
    assign addr_ri14 = reg1_i + si14_ext;

    always_comb begin
        is_mem_o   = 1'b1;
        we_o       = 1'b0;
        addr_o     = addr_ri12;
        wdata_o    = '0;
        wstrb_o    = WSTRB_FULL;
        misaligned = 1'b0;
        case (aluop_i)
            ALU_LDB, ALU_LDBU: begin
                misaligned = 1'b0;
            end
            ALU_LDH, ALU_LDHU: begin
                misaligned = addr_ri12[0];
            end
            ALU_LDW: begin
                misaligned = addr_ri12[1:0] != 2'b00;
            end
            ALU_LLW: begin
                addr_o     = addr_ri14;
                misaligned = addr_ri14[1:0] != 2'b00;
            end
            ALU_STB: begin
                we_o    = 1'b1;
                wdata_o = {24'b0, reg2_i[7:0]} << {addr_ri12[1:0], 3'b000};
                wstrb_o = WSTRB_BYTE << addr_ri12[1:0];
            end
            ALU_STH: begin
                we_o       = 1'b1;
                wdata_o    = {16'b0, reg2_i[15:0]} << {addr_ri12[1], 4'b0000};
                wstrb_o    = WSTRB_HALF << {addr_ri12[1], 1'b0};
                misaligned = addr_ri12[0];
            end
            ALU_STW: begin
                we_o       = 1'b1;
                wdata_o    = reg2_i;
                misaligned = addr_ri12[1:0] != 2'b00;
            end
            ALU_SCW: begin
                // store only goes out while the LL bit holds
                is_mem_o   = ll_bit_i;
                we_o       = ll_bit_i;
                addr_o     = addr_ri14;
                wdata_o    = reg2_i;
                misaligned = addr_ri14[1:0] != 2'b00;
            end
            default: begin
                is_mem_o = 1'b0;
            end
        endcase
    end

    assign exc_o       = is_mem_o && misaligned;
    assign exc_cause_o = exc_o ? EXC_ALE : EXC_NONE;

endmodule

// ==== rtl/regular_alu.sv ====
`timescale 1ns/1ps

module regular_alu (
    input  ex_op_pkg::alu_op_e    aluop_i,
    input  ex_op_pkg::inst_word_u inst_i,
    input  ex_op_pkg::word_t      pc_i,
    input  ex_op_pkg::word_t      reg1_i,
    input  ex_op_pkg::word_t      reg2_i,
    output ex_op_pkg::word_t      result_o
);
    import ex_op_pkg::*;

    word_t      imm_u12;
    logic [4:0] shamt;
    word_t      sum;
    word_t      diff;
    logic       lt_signed;
    logic       lt_unsigned;

    // si20 placed in the upper bits
    assign imm_u12 = {inst_i.fmt_ri20.si20, 12'b0};
    assign shamt   = reg2_i[4:0];

    assign sum  = reg1_i + reg2_i;
    assign diff = reg1_i - reg2_i;

    assign lt_signed   = $signed(reg1_i) < $signed(reg2_i);
    assign lt_unsigned = reg1_i < reg2_i;

    always_comb begin
        case (aluop_i)
            ALU_ADD:       result_o = sum;
            ALU_SUB:       result_o = diff;
            ALU_SLT:       result_o = {31'b0, lt_signed};
            ALU_SLTU:      result_o = {31'b0, lt_unsigned};
            ALU_AND:       result_o = reg1_i & reg2_i;
            ALU_OR:        result_o = reg1_i | reg2_i;
            ALU_NOR:       result_o = ~(reg1_i | reg2_i);
            ALU_XOR:       result_o = reg1_i ^ reg2_i;
            ALU_SLL:       result_o = reg1_i << shamt;
            ALU_SRL:       result_o = reg1_i >> shamt;
            ALU_SRA:       result_o = word_t'($signed(reg1_i) >>> shamt);
            ALU_LU12I:     result_o = imm_u12;
            // pc-relative upper immediate
            ALU_PCADDU12I: result_o = pc_i + imm_u12;
            default:       result_o = '0;
        endcase
    end

endmodule

// ==== verification/alu_properties.sv ====
`timescale 1ns/1ps

module alu_properties (
    input logic               clk,
    input logic               rst_n_i,
    input logic               pause_o,
    input logic               mem_valid_o,
    input logic               mem_addr_ok_i,
    input logic               mem_we_o,
    input logic               mem_uncached_o,
    input ex_op_pkg::word_t   mem_addr_o,
    input ex_op_pkg::word_t   mem_wdata_o,
    input ex_mem_pkg::wstrb_t mem_wstrb_o,
    input logic               exc_o
);

    int fail_count = 0;

    // a waiting request must stall the pipe
    ap_pause_on_wait: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_valid_o && !mem_addr_ok_i |-> pause_o)
        else begin
            $error("pause_o low while a cache request waits");
            fail_count++;
        end

    ap_request_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_valid_o && !mem_addr_ok_i |=> mem_valid_o && $stable(mem_addr_o) &&
            $stable(mem_wdata_o) && $stable(mem_wstrb_o) && $stable(mem_we_o) &&
            $stable(mem_uncached_o))
        else begin
            $error("cache request changed before mem_addr_ok_i");
            fail_count++;
        end

    ap_no_request_on_exc: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(mem_valid_o && exc_o))
        else begin
            $error("mem_valid_o raised together with an exception");
            fail_count++;
        end

endmodule

// ==== verification/alu_model.svh ====
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// expected results, worked out from the instruction rules

function automatic word_t regular_result(input alu_op_e op, input inst_word_u inst,
                                         input word_t pc, input word_t a, input word_t b);
    word_t upper;
    word_t fill;
    upper = {inst[24:5], 12'h000};
    // sign bits that an arithmetic shift brings in from the top
    fill  = a[31] ? ~(32'hffff_ffff >> b[4:0]) : '0;
    case (op)
        ALU_ADD:       return a + b;
        ALU_SUB:       return a - b;
        ALU_SLT:       return word_t'($signed(a) < $signed(b));
        ALU_SLTU:      return word_t'(a < b);
        ALU_AND:       return a & b;
        ALU_OR:        return a | b;
        ALU_NOR:       return ~(a | b);
        ALU_XOR:       return a ^ b;
        ALU_SLL:       return a << b[4:0];
        ALU_SRL:       return a >> b[4:0];
        ALU_SRA:       return (a >> b[4:0]) | fill;
        ALU_LU12I:     return upper;
        ALU_PCADDU12I: return pc + upper;
        default:       return '0;
    endcase
endfunction

function automatic word_t div_result(input alu_op_e op, input word_t a, input word_t b);
    logic  sgn;
    word_t q;
    word_t r;
    sgn = op inside {ALU_DIVW, ALU_MODW};
    if (b == '0) begin
        q = '1;
        r = a;
    end else if (sgn && a == 32'h8000_0000 && b == '1) begin
        // overflow case wraps back to the dividend
        q = a;
        r = '0;
    end else if (sgn) begin
        q = $signed(a) / $signed(b);
        r = $signed(a) % $signed(b);
    end else begin
        q = a / b;
        r = a % b;
    end
    return (op inside {ALU_DIVW, ALU_DIVWU}) ? q : r;
endfunction

function automatic void branch_outcome(input alu_op_e op, input inst_word_u inst,
                                       input word_t pc, input word_t a, input word_t b,
                                       input logic pt, input word_t ptgt,
                                       output word_t dest, output word_t target,
                                       output logic flush);
    word_t off16;
    word_t off26;
    logic  taken;
    off16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    off26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
    dest  = pc + off16;
    taken = 1'b1;
    case (op)
        ALU_BEQ:       taken = (a == b);
        ALU_BNE:       taken = (a != b);
        ALU_BLT:       taken = ($signed(a) < $signed(b));
        ALU_BGE:       taken = !($signed(a) < $signed(b));
        ALU_BLTU:      taken = (a < b);
        ALU_BGEU:      taken = !(a < b);
        ALU_B, ALU_BL: dest = pc + off26;
        ALU_JIRL:      dest = a + off16;
        default:       taken = 1'b0;
    endcase
    target = taken ? dest : pc + 32'd4;
    flush  = (taken != pt) || (taken && pt && dest != ptgt);
endfunction

function automatic void agen_expect(input alu_op_e op, input inst_word_u inst,
                                    input word_t a, input word_t b, input logic ll,
                                    output word_t addr, output word_t wdata,
                                    output wstrb_t strb, output logic we,
                                    output logic req, output logic exc);
    int    size;
    logic  mem;
    word_t mask;
    mem = !(op == ALU_SCW && !ll);
    we  = mem && (op inside {ALU_STB, ALU_STH, ALU_STW, ALU_SCW});
    if (op inside {ALU_LLW, ALU_SCW}) begin
        addr = a + {{16{inst[23]}}, inst[23:10], 2'b00};
    end else begin
        addr = a + {{20{inst[21]}}, inst[21:10]};
    end
    if (op inside {ALU_LDB, ALU_LDBU, ALU_STB}) begin
        size = 1;
    end else if (op inside {ALU_LDH, ALU_LDHU, ALU_STH}) begin
        size = 2;
    end else begin
        size = 4;
    end
    exc   = mem && (addr % size != 0);
    req   = mem && !exc;
    mask  = (size == 4) ? '1 : ((32'd1 << (8 * size)) - 1);
    wdata = (b & mask) << (8 * addr[1:0]);
    // loads always ask for the whole word
    strb  = we ? wstrb_t'(((1 << size) - 1) << addr[1:0]) : 4'b1111;
endfunction

`endif

// ==== verification/tb_alu.sv ====
`timescale 1ns/1ps

module tb_alu;
    import ex_op_pkg::*;
    import ex_mem_pkg::*;

    localparam int N_REG       = 40;
    localparam int N_DIV       = 24;
    localparam int N_BR        = 40;
    localparam int N_MEM       = 48;
    localparam int N_LLSC      = 16;
    localparam int N_ITEMS     = N_REG + N_DIV + N_BR + N_MEM + N_LLSC;
    localparam int CYCLE_LIMIT = N_ITEMS * 40 + 200;

    logic       clk = 1'b0;
    logic       rst_n_i;
    logic       ex_valid_i;
    word_t      pc_i;
    inst_word_u inst_i;
    alu_op_e    aluop_i;
    alu_sel_e   alusel_i;
    word_t      reg1_i;
    word_t      reg2_i;
    logic       pre_taken_i;
    word_t      pre_target_i;
    logic       ll_bit_i;
    logic       mem_addr_ok_i;
    logic       pause_o;
    logic       branch_flush_o;
    word_t      branch_target_o;
    logic       mem_valid_o;
    logic       mem_we_o;
    logic       mem_uncached_o;
    word_t      mem_addr_o;
    word_t      mem_wdata_o;
    wstrb_t     mem_wstrb_o;
    word_t      wb_data_o;
    logic       exc_o;
    exc_cause_e exc_cause_o;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          stall_init;
    int          stall_left;
    logic [31:0] lfsr_q = 32'd7223;

    alu i_alu (.*);

    bind alu alu_properties i_alu_properties (.*);

    always #5 clk = ~clk;

    // galois lfsr, one step per bit taken
    function automatic word_t lfsr_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    `include "alu_model.svh"

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_strobe(input string name, input wstrb_t exp, input wstrb_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_cause(input string name, input exc_cause_e exp, input exc_cause_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %s, actual %h", name, exp.name(), act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic expect_idle(input string name);
        check_flag({name, " pause_o"}, 1'b0, pause_o);
        check_flag({name, " mem_valid_o"}, 1'b0, mem_valid_o);
        check_flag({name, " branch_flush_o"}, 1'b0, branch_flush_o);
    endtask

    task automatic present_item(input alu_sel_e sel, input alu_op_e op);
        @(negedge clk);
        ex_valid_i    = 1'b1;
        alusel_i      = sel;
        aluop_i       = op;
        stall_init    = int'(lfsr_bits(2));
        stall_left    = stall_init;
        mem_addr_ok_i = (stall_left == 0);
    endtask

    task automatic random_operands();
        pc_i         = lfsr_bits(30) << 2;
        inst_i       = lfsr_bits(32);
        reg1_i       = lfsr_bits(32);
        reg2_i       = lfsr_bits(32);
        pre_taken_i  = lfsr_bits(1) != '0;
        pre_target_i = lfsr_bits(30) << 2;
        ll_bit_i     = lfsr_bits(1) != '0;
    endtask

    // count stall cycles until the item is accepted, checking a waiting request
    task automatic wait_accept(input string name, output int pauses);
        word_t  addr_held;
        word_t  wdata_held;
        wstrb_t strb_held;
        pauses = 0;
        #1;
        addr_held  = mem_addr_o;
        wdata_held = mem_wdata_o;
        strb_held  = mem_wstrb_o;
        while (pause_o) begin
            @(negedge clk);
            if (stall_left > 0) stall_left--;
            mem_addr_ok_i = (stall_left == 0);
            #1;
            pauses++;
            if (mem_valid_o) begin
                check_word({name, " held addr"}, addr_held, mem_addr_o);
                check_word({name, " held wdata"}, wdata_held, mem_wdata_o);
                check_strobe({name, " held wstrb"}, strb_held, mem_wstrb_o);
            end
        end
    endtask

    task automatic run_mem_item(input string name);
        word_t  addr;
        word_t  wdata;
        wstrb_t strb;
        logic   we;
        logic   req;
        logic   exc;
        int     pauses;
        agen_expect(aluop_i, inst_i, reg1_i, reg2_i, ll_bit_i, addr, wdata, strb, we, req, exc);
        wait_accept(name, pauses);
        check_word({name, " stall cycles"}, req ? stall_init : 0, pauses);
        check_flag({name, " mem_valid_o"}, req, mem_valid_o);
        check_flag({name, " exc_o"}, exc, exc_o);
        check_cause({name, " exc_cause_o"}, exc ? EXC_ALE : EXC_NONE, exc_cause_o);
        if (req) begin
            check_word({name, " mem_addr_o"}, addr, mem_addr_o);
            check_strobe({name, " mem_wstrb_o"}, strb, mem_wstrb_o);
            check_flag({name, " mem_we_o"}, we, mem_we_o);
            check_flag({name, " mem_uncached_o"}, addr[31:16] == UNCACHED_PREFIX, mem_uncached_o);
        end
        if (req && we) begin
            check_word({name, " mem_wdata_o"}, wdata, mem_wdata_o);
        end
        check_word({name, " wb_data_o"}, (aluop_i == ALU_SCW) ? word_t'(ll_bit_i) : '0, wb_data_o);
    endtask

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test failed");
        $finish;
    end

    initial begin
        int    pauses;
        int    k;
        word_t dest;
        word_t target;
        logic  flush;
        rst_n_i       = 1'b0;
        ex_valid_i    = 1'b0;
        pc_i          = '0;
        inst_i        = '0;
        aluop_i       = ALU_NOP;
        alusel_i      = SEL_NONE;
        reg1_i        = '0;
        reg2_i        = '0;
        pre_taken_i   = 1'b0;
        pre_target_i  = '0;
        ll_bit_i      = 1'b0;
        mem_addr_ok_i = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        #1;
        expect_idle("after reset");

        for (int i = 0; i < N_REG; i++) begin
            present_item(SEL_REGULAR, alu_op_e'(lfsr_bits(4) % 13));
            random_operands();
            wait_accept("regular", pauses);
            check_word("regular pause cycles", '0, word_t'(pauses));
            check_word($sformatf("regular %s", aluop_i.name()),
                       regular_result(aluop_i, inst_i, pc_i, reg1_i, reg2_i), wb_data_o);
        end

        // back to back, so a stray restart would show in the cycle count
        for (int i = 0; i < N_DIV; i++) begin
            present_item(SEL_DIV, alu_op_e'(int'(ALU_DIVW) + int'(lfsr_bits(2))));
            random_operands();
            case (lfsr_bits(3))
                0: reg2_i = '0;
                1: reg1_i = 32'h8000_0000;
                2: begin
                    reg1_i = 32'h8000_0000;
                    reg2_i = '1;
                end
                3: reg2_i = lfsr_bits(1) ? -lfsr_bits(8) : lfsr_bits(8);
                default: ;
            endcase
            wait_accept("div", pauses);
            check_word("div pause cycles", word_t'(DIV_STEPS + 1), word_t'(pauses));
            check_word($sformatf("div %s %h %h", aluop_i.name(), reg1_i, reg2_i),
                       div_result(aluop_i, reg1_i, reg2_i), wb_data_o);
        end

        for (int i = 0; i < N_BR; i++) begin
            present_item(SEL_BRANCH, alu_op_e'(int'(ALU_BEQ) + int'(lfsr_bits(4) % 9)));
            random_operands();
            if (lfsr_bits(2) == 0) reg2_i = reg1_i;
            branch_outcome(aluop_i, inst_i, pc_i, reg1_i, reg2_i, pre_taken_i, pre_target_i,
                           dest, target, flush);
            if (lfsr_bits(1)) begin
                pre_target_i = dest;
                branch_outcome(aluop_i, inst_i, pc_i, reg1_i, reg2_i, pre_taken_i,
                               pre_target_i, dest, target, flush);
            end
            wait_accept("branch", pauses);
            check_word("branch pause cycles", '0, word_t'(pauses));
            check_word($sformatf("branch %s target", aluop_i.name()), target, branch_target_o);
            check_flag($sformatf("branch %s flush", aluop_i.name()), flush, branch_flush_o);
            check_word($sformatf("branch %s link", aluop_i.name()), pc_i + 32'd4, wb_data_o);
        end

        for (int i = 0; i < N_MEM; i++) begin
            k = int'(lfsr_bits(3));
            present_item(SEL_LOAD_STORE, (k < 5) ? alu_op_e'(int'(ALU_LDB) + k) :
                                                   alu_op_e'(int'(ALU_STB) + k - 5));
            random_operands();
            if (lfsr_bits(1)) reg1_i[31:16] = UNCACHED_PREFIX;
            run_mem_item($sformatf("mem %s", aluop_i.name()));
        end

        for (int i = 0; i < N_LLSC; i++) begin
            present_item(SEL_LOAD_STORE, lfsr_bits(1) ? ALU_LLW : ALU_SCW);
            random_operands();
            if (lfsr_bits(2) != 0) reg1_i[1:0] = 2'b00;
            run_mem_item($sformatf("llsc %s ll=%b", aluop_i.name(), ll_bit_i));
        end

        @(negedge clk);
        ex_valid_i = 1'b0;
        #1;
        expect_idle("final idle");
        $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 i_alu.i_alu_properties.fail_count);
        if (errors == 0 && i_alu.i_alu_properties.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
